// ==== design/cache_defines.svh ====
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// address and data widths.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CACHE_ADDR_W 16
`define CACHE_WORD_W 32

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two ways, eight sets, four words per line.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CACHE_SETS 8
`define CACHE_INDEX_W 3
`define CACHE_LINE_WORDS 4
`define CACHE_OFFSET_W 2

// tag is what is left of the word address.
`define CACHE_TAG_W 11

`endif

// ==== design/cache_array_pkg.sv ====
`include "cache_defines.svh"

package cache_array_pkg;

	typedef logic [`CACHE_TAG_W-1:0] tag_t;
	typedef logic [`CACHE_INDEX_W-1:0] index_t;
	typedef logic [`CACHE_OFFSET_W-1:0] offset_t;
	typedef logic [`CACHE_LINE_WORDS-1:0][`CACHE_WORD_W-1:0] line_t;

	typedef struct packed {
		logic valid;
		logic dirty;
		tag_t tag;
	} meta_t;

	// fill_sel high takes memory data, low takes the merged processor write.
	typedef struct packed {
		logic dirty_load;
		logic dirty_in;
		logic valid_load;
		logic valid_in;
		logic tag_load;
		logic data_load;
		logic fill_sel;
	} way_ctrl_t;

	typedef struct packed {
		logic hit;
		logic valid;
		logic dirty;
	} way_status_t;

endpackage : cache_array_pkg

// ==== design/cache_bus_pkg.sv ====
`include "cache_defines.svh"

package cache_bus_pkg;

	typedef struct packed {
		logic read;
		logic write;
		logic [`CACHE_ADDR_W-1:0] addr;
		logic [`CACHE_WORD_W-1:0] wdata;
		logic [`CACHE_WORD_W/8-1:0] byte_en;
	} cpu_req_t;

	typedef struct packed {
		logic resp;
		logic [`CACHE_WORD_W-1:0] rdata;
	} cpu_rsp_t;

	// addr is a word address, line base plus beat.
	typedef struct packed {
		logic read;
		logic write;
		logic [`CACHE_ADDR_W-1:0] addr;
		logic [`CACHE_WORD_W-1:0] wdata;
	} pmem_req_t;

	typedef struct packed {
		logic resp;
		logic [`CACHE_WORD_W-1:0] rdata;
	} pmem_rsp_t;

endpackage : cache_bus_pkg

// ==== design/line_beat_counter.sv ====
`timescale 1ns/100ps
`include "cache_defines.svh"

module line_beat_counter
	import cache_array_pkg::*;
(
	input  logic    clk,
	input  logic    arst_n,
	input  logic    busy,
	input  logic    beat_ack,
	output offset_t beat,
	output logic    line_done
);

	logic last_beat;

	assign last_beat = (beat == offset_t'(`CACHE_LINE_WORDS - 1));

	// done on the ack of the final word of the line.
	assign line_done = busy && beat_ack && last_beat;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			beat <= '0;
		end else if (!busy) begin
			beat <= '0;
		end else if (beat_ack) begin
			// wraps to zero after the last beat.
			beat <= beat + 1'b1;
		end
	end

endmodule : line_beat_counter

// ==== design/cache_way_array.sv ====
`timescale 1ns/100ps
`include "cache_defines.svh"

module cache_way_array
	import cache_array_pkg::*;
#(
	parameter type entry_t = logic [7:0],
	parameter bit RESET_ENTRIES = 1'b1
) (
	input  logic   clk,
	input  logic   arst_n,
	input  logic   read,
	input  index_t rindex,
	input  index_t windex,
	input  logic   load,
	input  entry_t wdata,
	output entry_t rdata
);

	entry_t mem [`CACHE_SETS];

	// a load also refreshes the output so partial fills build on themselves.
	if (RESET_ENTRIES) begin : g_reset
		always_ff @(posedge clk or negedge arst_n) begin
			if (!arst_n) begin
				for (int i = 0; i < `CACHE_SETS; i++) begin
					mem[i] <= '0;
				end
				rdata <= '0;
			end else if (load) begin
				mem[windex] <= wdata;
				rdata <= wdata;
			end else if (read) begin
				rdata <= mem[rindex];
			end
		end
	end else begin : g_no_reset
		always_ff @(posedge clk) begin
			if (load) begin
				mem[windex] <= wdata;
				rdata <= wdata;
			end else if (read) begin
				rdata <= mem[rindex];
			end
		end
	end

endmodule : cache_way_array

// ==== design/lru_array.sv ====
`timescale 1ns/100ps
`include "cache_defines.svh"

module lru_array
	import cache_array_pkg::*;
(
	input  logic   clk,
	input  logic   arst_n,
	input  logic   read,
	input  index_t index,
	input  logic   load,
	input  logic   lru_in,
	output logic   lru_out
);

	// one bit per set, it names the way to evict next.
	logic [`CACHE_SETS-1:0] lru_bits;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			lru_bits <= '0;
			lru_out <= 1'b0;
		end else if (load) begin
			lru_bits[index] <= lru_in;
			lru_out <= lru_in;
		end else if (read) begin
			lru_out <= lru_bits[index];
		end
	end

endmodule : lru_array

// ==== design/cache_control.sv ====
`timescale 1ns/100ps

module cache_control
	import cache_array_pkg::*;
	import cache_bus_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  cpu_req_t    cpu_req,
	input  way_status_t way_status [2],
	input  logic        lru_out,
	input  logic        line_done,
	output logic        arrays_read,
	output way_ctrl_t   way_ctrl [2],
	output logic        lru_load,
	output logic        lru_in,
	output logic        pmem_write_sel,
	output logic        resp,
	output logic        pmem_read,
	output logic        pmem_write
);

	typedef enum logic [1:0] {
		idle,
		check,
		allocate,
		writeback
	} state_t;

	state_t state;
	state_t next_state;
	logic   req_valid;
	logic   any_hit;
	logic   hit_way;
	logic   victim;

	assign req_valid = cpu_req.read || cpu_req.write;
	assign any_hit = way_status[0].hit || way_status[1].hit;
	assign hit_way = way_status[1].hit;
	assign victim = lru_out;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// outputs per state.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		arrays_read = 1'b0;
		way_ctrl[0] = '0;
		way_ctrl[1] = '0;
		lru_load = 1'b0;
		lru_in = 1'b0;
		pmem_write_sel = 1'b0;
		resp = 1'b0;
		pmem_read = 1'b0;
		pmem_write = 1'b0;

		case (state)
			idle: begin
				if (req_valid) begin
					arrays_read = 1'b1;
				end
			end

			check: begin
				if (req_valid && any_hit) begin
					resp = 1'b1;
					// next victim is the way that did not hit.
					lru_load = 1'b1;
					lru_in = ~hit_way;
					if (cpu_req.write) begin
						way_ctrl[hit_way].dirty_load = 1'b1;
						way_ctrl[hit_way].dirty_in = 1'b1;
						way_ctrl[hit_way].data_load = 1'b1;
					end
				end
			end

			allocate: begin
				pmem_read = 1'b1;
				way_ctrl[victim].data_load = 1'b1;
				way_ctrl[victim].fill_sel = 1'b1;
				// the line turns valid only once every beat is in.
				if (line_done) begin
					way_ctrl[victim].tag_load = 1'b1;
					way_ctrl[victim].valid_load = 1'b1;
					way_ctrl[victim].valid_in = 1'b1;
					way_ctrl[victim].dirty_load = 1'b1;
				end
			end

			writeback: begin
				pmem_write = 1'b1;
				pmem_write_sel = 1'b1;
				if (line_done) begin
					way_ctrl[victim].dirty_load = 1'b1;
				end
			end

			default: ;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// next state.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		next_state = state;
		case (state)
			idle: begin
				if (req_valid) begin
					next_state = check;
				end
			end

			check: begin
				if (!req_valid || any_hit) begin
					next_state = idle;
				end else if (way_status[victim].valid && way_status[victim].dirty) begin
					next_state = writeback;
				end else begin
					next_state = allocate;
				end
			end

			allocate, writeback: begin
				if (line_done) begin
					next_state = idle;
				end
			end

			default: next_state = idle;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= idle;
		end else begin
			state <= next_state;
		end
	end

endmodule : cache_control

// ==== design/cache_datapath.sv ====
`timescale 1ns/100ps
`include "cache_defines.svh"

module cache_datapath
	import cache_array_pkg::*;
	import cache_bus_pkg::*;
(
	input  logic                     clk,
	input  logic                     arst_n,
	input  cpu_req_t                 cpu_req,
	input  logic                     arrays_read,
	input  way_ctrl_t                way_ctrl [2],
	input  logic                     lru_out,
	input  logic                     pmem_write_sel,
	input  offset_t                  beat,
	input  pmem_rsp_t                pmem_rsp,
	output way_status_t              way_status [2],
	output logic [`CACHE_WORD_W-1:0] rdata,
	output logic [`CACHE_ADDR_W-1:0] pmem_addr,
	output logic [`CACHE_WORD_W-1:0] pmem_wdata
);

	tag_t    req_tag;
	index_t  req_index;
	offset_t req_offset;
	tag_t    victim_tag;
	meta_t   meta_rd [2];
	line_t   line_rd [2];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// address split.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign req_offset = cpu_req.addr[`CACHE_OFFSET_W-1:0];
	assign req_index = cpu_req.addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W];
	assign req_tag = cpu_req.addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];

	for (genvar w = 0; w < 2; w++) begin : g_way
		meta_t meta_wr;
		line_t line_wr;
		logic  meta_load;
		logic  line_load;

		assign way_status[w] = '{
			hit: meta_rd[w].valid && (meta_rd[w].tag == req_tag),
			valid: meta_rd[w].valid,
			dirty: meta_rd[w].dirty
		};

		assign meta_load = way_ctrl[w].valid_load || way_ctrl[w].dirty_load ||
			way_ctrl[w].tag_load;
		// fill words only land when memory acks a beat.
		assign line_load = way_ctrl[w].data_load && (!way_ctrl[w].fill_sel || pmem_rsp.resp);

		always_comb begin
			meta_wr = meta_rd[w];
			if (way_ctrl[w].valid_load) begin
				meta_wr.valid = way_ctrl[w].valid_in;
			end
			if (way_ctrl[w].dirty_load) begin
				meta_wr.dirty = way_ctrl[w].dirty_in;
			end
			if (way_ctrl[w].tag_load) begin
				meta_wr.tag = req_tag;
			end

			line_wr = line_rd[w];
			if (way_ctrl[w].fill_sel) begin
				line_wr[beat] = pmem_rsp.rdata;
			end else begin
				for (int b = 0; b < `CACHE_WORD_W/8; b++) begin
					if (cpu_req.byte_en[b]) begin
						line_wr[req_offset][8*b +: 8] = cpu_req.wdata[8*b +: 8];
					end
				end
			end
		end

		cache_way_array #(.entry_t(meta_t), .RESET_ENTRIES(1'b1)) u_meta (
			.clk    (clk),
			.arst_n (arst_n),
			.read   (arrays_read),
			.rindex (req_index),
			.windex (req_index),
			.load   (meta_load),
			.wdata  (meta_wr),
			.rdata  (meta_rd[w])
		);

		cache_way_array #(.entry_t(line_t), .RESET_ENTRIES(1'b0)) u_data (
			.clk    (clk),
			.arst_n (arst_n),
			.read   (arrays_read),
			.rindex (req_index),
			.windex (req_index),
			.load   (line_load),
			.wdata  (line_wr),
			.rdata  (line_rd[w])
		);
	end

	assign rdata = way_status[1].hit ? line_rd[1][req_offset] : line_rd[0][req_offset];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// memory side, victim tag for writeback.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign victim_tag = meta_rd[lru_out].tag;
	assign pmem_addr = {pmem_write_sel ? victim_tag : req_tag, req_index, beat};
	assign pmem_wdata = line_rd[lru_out][beat];

endmodule : cache_datapath

// ==== design/cache_top.sv ====
`timescale 1ns/100ps
`include "cache_defines.svh"

module cache_top
	import cache_array_pkg::*;
	import cache_bus_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n,
	input  cpu_req_t  cpu_req,
	output cpu_rsp_t  cpu_rsp,
	output pmem_req_t pmem_req,
	input  pmem_rsp_t pmem_rsp
);

	logic                     arrays_read;
	way_ctrl_t                way_ctrl [2];
	way_status_t              way_status [2];
	logic                     lru_load;
	logic                     lru_in;
	logic                     lru_out;
	logic                     pmem_write_sel;
	logic                     ctrl_resp;
	logic                     pmem_read;
	logic                     pmem_write;
	offset_t                  beat;
	logic                     line_done;
	logic [`CACHE_WORD_W-1:0] rdata;
	logic [`CACHE_ADDR_W-1:0] pmem_addr;
	logic [`CACHE_WORD_W-1:0] pmem_wdata;

	assign cpu_rsp = '{resp: ctrl_resp, rdata: rdata};
	assign pmem_req = '{read: pmem_read, write: pmem_write, addr: pmem_addr, wdata: pmem_wdata};

	cache_control u_cache_control (
		.clk            (clk),
		.arst_n         (arst_n),
		.cpu_req        (cpu_req),
		.way_status     (way_status),
		.lru_out        (lru_out),
		.line_done      (line_done),
		.arrays_read    (arrays_read),
		.way_ctrl       (way_ctrl),
		.lru_load       (lru_load),
		.lru_in         (lru_in),
		.pmem_write_sel (pmem_write_sel),
		.resp           (ctrl_resp),
		.pmem_read      (pmem_read),
		.pmem_write     (pmem_write)
	);

	line_beat_counter u_line_beat_counter (
		.clk       (clk),
		.arst_n    (arst_n),
		.busy      (pmem_read || pmem_write),
		.beat_ack  (pmem_rsp.resp),
		.beat      (beat),
		.line_done (line_done)
	);

	lru_array u_lru_array (
		.clk     (clk),
		.arst_n  (arst_n),
		.read    (arrays_read),
		.index   (cpu_req.addr[`CACHE_OFFSET_W +: `CACHE_INDEX_W]),
		.load    (lru_load),
		.lru_in  (lru_in),
		.lru_out (lru_out)
	);

	cache_datapath u_cache_datapath (
		.clk            (clk),
		.arst_n         (arst_n),
		.cpu_req        (cpu_req),
		.arrays_read    (arrays_read),
		.way_ctrl       (way_ctrl),
		.lru_out        (lru_out),
		.pmem_write_sel (pmem_write_sel),
		.beat           (beat),
		.pmem_rsp       (pmem_rsp),
		.way_status     (way_status),
		.rdata          (rdata),
		.pmem_addr      (pmem_addr),
		.pmem_wdata     (pmem_wdata)
	);

endmodule : cache_top

// ==== bench/cache_asserts.sv ====
`timescale 1ns/100ps
`include "cache_defines.svh"

module cache_asserts
	import cache_bus_pkg::*;
(
	input logic      clk,
	input logic      arst_n,
	input cpu_req_t  cpu_req,
	input cpu_rsp_t  cpu_rsp,
	input pmem_req_t pmem_req,
	input logic      line_done
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// memory side strobes.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	a_no_read_and_write: assert property (@(posedge clk) disable iff (!arst_n)
		!(pmem_req.read && pmem_req.write))
		else $error("pmem read and write are high together");

	a_read_held: assert property (@(posedge clk) disable iff (!arst_n)
		pmem_req.read && !line_done |=> pmem_req.read)
		else $error("pmem read dropped before the line was done");

	a_write_held: assert property (@(posedge clk) disable iff (!arst_n)
		pmem_req.write && !line_done |=> pmem_req.write)
		else $error("pmem write dropped before the line was done");

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// processor side response.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	a_resp_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		cpu_rsp.resp |=> !cpu_rsp.resp)
		else $error("resp stayed high for more than one cycle");

	a_resp_with_req: assert property (@(posedge clk) disable iff (!arst_n)
		cpu_rsp.resp |-> (cpu_req.read || cpu_req.write))
		else $error("resp without a held request");

endmodule : cache_asserts

bind cache_top cache_asserts u_cache_asserts (
	.clk       (clk),
	.arst_n    (arst_n),
	.cpu_req   (cpu_req),
	.cpu_rsp   (cpu_rsp),
	.pmem_req  (pmem_req),
	.line_done (line_done)
);

// ==== bench/cache_tb.sv ====
`timescale 1ns/100ps
`include "cache_defines.svh"

module cache_tb
	import cache_array_pkg::*;
	import cache_bus_pkg::*;
();

	localparam int LINE_WORDS = `CACHE_LINE_WORDS;
	localparam int MEM_LATENCY = 2;
	localparam int NUM_ACCESSES = 56;
	localparam int TIMEOUT_CYCLES =
		NUM_ACCESSES * (2 * LINE_WORDS * (MEM_LATENCY + 1) + 8) + 200;

	typedef logic [`CACHE_ADDR_W-1:0] addr_t;
	typedef logic [`CACHE_WORD_W-1:0] word_t;
	typedef logic [`CACHE_WORD_W/8-1:0] be_t;

	logic      clk = 1'b0;
	logic      arst_n = 1'b0;
	cpu_req_t  cpu_req = '0;
	cpu_rsp_t  cpu_rsp;
	pmem_req_t pmem_req;
	pmem_rsp_t pmem_rsp = '0;

	word_t       backing [int];
	word_t       shadow [int];
	pmem_req_t   read_log [$];
	pmem_req_t   write_log [$];
	int          wait_cnt = 0;
	int          cycle_count = 0;
	int          checks = 0;
	int          errors = 0;
	logic [15:0] lfsr = 16'd8110;

	cache_top u_cache_top (
		.clk      (clk),
		.arst_n   (arst_n),
		.cpu_req  (cpu_req),
		.cpu_rsp  (cpu_rsp),
		.pmem_req (pmem_req),
		.pmem_rsp (pmem_rsp)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// memory model answering one beat every MEM_LATENCY+1 cycles.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(posedge clk) begin
		if (pmem_rsp.resp) begin
			pmem_rsp <= '0;
			wait_cnt <= 0;
		end else if (pmem_req.read || pmem_req.write) begin
			if (wait_cnt == MEM_LATENCY - 1) begin
				wait_cnt <= 0;
				if (pmem_req.write) begin
					backing[int'(pmem_req.addr)] = pmem_req.wdata;
					write_log.push_back(pmem_req);
					pmem_rsp <= '{resp: 1'b1, rdata: '0};
				end else begin
					read_log.push_back(pmem_req);
					pmem_rsp <= '{resp: 1'b1, rdata: backing_word(pmem_req.addr)};
				end
			end else begin
				wait_cnt <= wait_cnt + 1;
			end
		end else begin
			wait_cnt <= 0;
		end
	end

	// untouched words follow a pattern of the whole address.
	function automatic word_t fill_word(input addr_t a);
		return {a ^ 16'h3c5a, a * 16'd41 + 16'h1f0b};
	endfunction

	function automatic word_t backing_word(input addr_t a);
		return backing.exists(int'(a)) ? backing[int'(a)] : fill_word(a);
	endfunction

	function automatic word_t shadow_word(input addr_t a);
		return shadow.exists(int'(a)) ? shadow[int'(a)] : fill_word(a);
	endfunction

	// x^16 + x^14 + x^13 + x^11 + 1.
	function automatic word_t rand_bits(input int n);
		word_t v;
		logic  fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			v = {v[`CACHE_WORD_W-2:0], lfsr[15]};
			lfsr = {lfsr[14:0], fb};
		end
		return v;
	endfunction

	function automatic addr_t make_addr(input tag_t t, input index_t i, input offset_t o);
		return {t, i, o};
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// compare tasks.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic check_rdata(input string name, input cpu_rsp_t got, input cpu_rsp_t exp);
		checks++;
		if (got.rdata !== exp.rdata) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h",
				$time, name, got.rdata, exp.rdata);
		end
	endtask

	task automatic check_pmem_write(input pmem_req_t got, input pmem_req_t exp);
		checks++;
		if (got.addr !== exp.addr || got.wdata !== exp.wdata) begin
			errors++;
			$display("CHECK FAILED at %0t: pmem_req.addr/wdata got %h/%h expected %h/%h",
				$time, got.addr, got.wdata, exp.addr, exp.wdata);
		end
	endtask

	task automatic check_pmem_read(input pmem_req_t got, input pmem_req_t exp);
		checks++;
		if (got.addr !== exp.addr) begin
			errors++;
			$display("CHECK FAILED at %0t: pmem_req.addr got %h expected %h",
				$time, got.addr, exp.addr);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_low(input string name, input logic got);
		checks++;
		if (got !== 1'b0) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %b expected 0", $time, name, got);
		end
	endtask

	task automatic end_test(input string name, input int errors_before);
		$display("%s: %0d errors", name, errors - errors_before);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// processor accesses.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic cpu_access(input logic wr, input addr_t a, input word_t d, input be_t be,
		output cpu_rsp_t rsp, output int cycles);
		cpu_req_t req;
		req = '{read: !wr, write: wr, addr: a, wdata: d, byte_en: be};
		cycles = 0;
		@(posedge clk);
		cpu_req <= req;
		do begin
			@(negedge clk);
			cycles++;
		end while (!cpu_rsp.resp);
		rsp = cpu_rsp;
		@(posedge clk);
		cpu_req <= '0;
	endtask

	task automatic read_check(input addr_t a, output int cycles);
		cpu_rsp_t rsp;
		cpu_rsp_t exp;
		cpu_access(1'b0, a, '0, '0, rsp, cycles);
		exp = '{resp: 1'b1, rdata: shadow_word(a)};
		check_rdata("cpu_rsp.rdata", rsp, exp);
	endtask

	task automatic write_word(input addr_t a, input word_t d, input be_t be);
		cpu_rsp_t rsp;
		int       cycles;
		word_t    merged;
		cpu_access(1'b1, a, d, be, rsp, cycles);
		merged = shadow_word(a);
		for (int b = 0; b < `CACHE_WORD_W/8; b++) begin
			if (be[b]) begin
				merged[8*b +: 8] = d[8*b +: 8];
			end
		end
		shadow[int'(a)] = merged;
	endtask

	task automatic check_read_beats(input int mark, input addr_t a, input int beats);
		pmem_req_t exp;
		check_count("pmem read beats", read_log.size() - mark, beats);
		for (int i = 0; i < beats; i++) begin
			exp = '{read: 1'b1, write: 1'b0, wdata: '0,
				addr: {a[`CACHE_ADDR_W-1:`CACHE_OFFSET_W], offset_t'(i)}};
			if (mark + i < read_log.size()) begin
				check_pmem_read(read_log[mark + i], exp);
			end
		end
	endtask

	// a read that must bring in the given number of beats and write none.
	task automatic read_expect(input addr_t a, input int beats, output int cycles);
		int rd_mark;
		int wr_mark;
		rd_mark = read_log.size();
		wr_mark = write_log.size();
		read_check(a, cycles);
		check_read_beats(rd_mark, a, beats);
		check_count("pmem write beats", write_log.size() - wr_mark, 0);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// directed tests.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic reset_and_first_read(output addr_t a);
		int      e0;
		int      cycles;
		tag_t    t;
		offset_t o;
		e0 = errors;
		@(negedge clk);
		check_low("cpu_rsp.resp", cpu_rsp.resp);
		check_low("pmem_req.read", pmem_req.read);
		check_low("pmem_req.write", pmem_req.write);
		t = tag_t'(rand_bits(`CACHE_TAG_W));
		o = offset_t'(rand_bits(`CACHE_OFFSET_W));
		a = make_addr(t, index_t'(1), o);
		read_expect(a, LINE_WORDS, cycles);
		end_test("reset and first read", e0);
	endtask

	task automatic same_line_hit(input addr_t a);
		int e0;
		int cycles;
		e0 = errors;
		read_expect({a[`CACHE_ADDR_W-1:`CACHE_OFFSET_W], a[1:0] + 2'd1}, 0, cycles);
		check_count("hit latency", cycles, 2);
		end_test("same line hit", e0);
	endtask

	task automatic write_hit_merge(input addr_t a);
		int    e0;
		int    cycles;
		int    wr_mark;
		int    rd_mark;
		addr_t wa;
		word_t d;
		be_t   be;
		e0 = errors;
		wa = {a[`CACHE_ADDR_W-1:`CACHE_OFFSET_W], offset_t'(rand_bits(`CACHE_OFFSET_W))};
		d = rand_bits(`CACHE_WORD_W);
		be = be_t'(rand_bits(`CACHE_WORD_W/8));
		wr_mark = write_log.size();
		rd_mark = read_log.size();
		write_word(wa, d, be);
		check_count("pmem beats on write hit", read_log.size() - rd_mark +
			write_log.size() - wr_mark, 0);
		read_expect(wa, 0, cycles);
		end_test("write hit merge", e0);
	endtask

	task automatic lru_replacement();
		int   e0;
		int   cycles;
		tag_t t;
		e0 = errors;
		t = tag_t'(rand_bits(`CACHE_TAG_W));
		read_expect(make_addr(t, index_t'(2), 2'd0), LINE_WORDS, cycles);
		read_expect(make_addr(t + 1'b1, index_t'(2), 2'd1), LINE_WORDS, cycles);
		read_expect(make_addr(t, index_t'(2), 2'd2), 0, cycles);
		// c takes the way of b as the least recently used line.
		read_expect(make_addr(t + 2'd2, index_t'(2), 2'd3), LINE_WORDS, cycles);
		read_expect(make_addr(t, index_t'(2), 2'd1), 0, cycles);
		read_expect(make_addr(t + 1'b1, index_t'(2), 2'd0), LINE_WORDS, cycles);
		end_test("lru replacement", e0);
	endtask

	task automatic dirty_eviction();
		int        e0;
		int        cycles;
		int        rd_mark;
		int        wr_mark;
		tag_t      t;
		addr_t     wa;
		word_t     d;
		be_t       be;
		pmem_req_t exp;
		e0 = errors;
		t = tag_t'(rand_bits(`CACHE_TAG_W));
		d = rand_bits(`CACHE_WORD_W);
		be = be_t'(rand_bits(`CACHE_WORD_W/8));
		write_word(make_addr(t, index_t'(3), 2'd0), d, be);
		d = rand_bits(`CACHE_WORD_W);
		be = be_t'(rand_bits(`CACHE_WORD_W/8));
		write_word(make_addr(t, index_t'(3), 2'd3), d, be);
		read_expect(make_addr(t + 1'b1, index_t'(3), 2'd1), LINE_WORDS, cycles);
		rd_mark = read_log.size();
		wr_mark = write_log.size();
		read_check(make_addr(t + 2'd2, index_t'(3), 2'd2), cycles);
		check_count("pmem write beats", write_log.size() - wr_mark, LINE_WORDS);
		for (int i = 0; i < LINE_WORDS; i++) begin
			wa = make_addr(t, index_t'(3), offset_t'(i));
			exp = '{read: 1'b0, write: 1'b1, addr: wa, wdata: shadow_word(wa)};
			if (wr_mark + i < write_log.size()) begin
				check_pmem_write(write_log[wr_mark + i], exp);
			end
		end
		check_read_beats(rd_mark, make_addr(t + 2'd2, index_t'(3), 2'd2), LINE_WORDS);
		// a clean victim next and then the written-back line comes home.
		read_expect(make_addr(t + 2'd3, index_t'(3), 2'd0), LINE_WORDS, cycles);
		read_expect(make_addr(t, index_t'(3), 2'd3), LINE_WORDS, cycles);
		end_test("dirty eviction", e0);
	endtask

	task automatic random_mix();
		int      e0;
		int      cycles;
		tag_t    base;
		tag_t    t;
		index_t  i;
		offset_t o;
		word_t   d;
		be_t     be;
		e0 = errors;
		base = tag_t'(rand_bits(`CACHE_TAG_W));
		for (int n = 0; n < 40; n++) begin
			t = base + tag_t'(rand_bits(2));
			i = index_t'(4 + rand_bits(1));
			o = offset_t'(rand_bits(`CACHE_OFFSET_W));
			if (rand_bits(1) == 1) begin
				d = rand_bits(`CACHE_WORD_W);
				be = be_t'(rand_bits(`CACHE_WORD_W/8));
				write_word(make_addr(t, i, o), d, be);
			end else begin
				read_check(make_addr(t, i, o), cycles);
			end
		end
		end_test("random mix", e0);
	endtask

	initial begin
		addr_t first_addr;
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		reset_and_first_read(first_addr);
		same_line_hit(first_addr);
		write_hit_merge(first_addr);
		lru_replacement();
		dirty_eviction();
		random_mix();
		$display("summary: %0d checks, %0d errors, %0d cycles", checks, errors, cycle_count);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule : cache_tb

// ==== vlog.f ====
+incdir+design
design/cache_array_pkg.sv
design/cache_bus_pkg.sv
design/line_beat_counter.sv
design/cache_way_array.sv
design/lru_array.sv
design/cache_control.sv
design/cache_datapath.sv
design/cache_top.sv
bench/cache_asserts.sv
bench/cache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= cache_tb
OBJ_DIR ?= obj_dir
FILELIST ?= vlog.f
VFLAGS ?= --binary --timing --assert --timescale 1ns/100ps
PASS_MSG ?= TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
